// File: flist.f
mem_if_pkg.sv
noc_msg_pkg.sv
bridge_fifo.sv
mem_req_issuer.sv
mem_resp_formatter.sv
noc_mem_bridge.sv
tb_noc_mem_bridge.sv

// File: run.sh
#!/bin/sh
# Compile and run the bridge testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_noc_mem_bridge -f flist.f -o sim_bridge &&
./obj_dir/sim_bridge ||
{ echo "Simulation run failed"; exit 1; }

// File: tb_noc_mem_bridge.sv
// Testbench for the NoC memory bridge
// Drives NoC requests, models the memory side and checks every transfer
`timescale 1ns/10ps

module tb_noc_mem_bridge;

  localparam int                IN_FLIGHT_DEPTH   = 4;
  localparam int                OUTSTANDING_DEPTH = 4;
  localparam mem_if_pkg::addr_t ADDR_OFFSET       = 40'h00_0010_0000;  // Aligned base
  localparam int                TIMEOUT           = 200;               // Cycles per wait

  // Issued request together with the word memory returns for it
  typedef struct packed {
    noc_msg_pkg::noc_req_t req;
    mem_if_pkg::data_t     mdata;
  } pend_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  noc_msg_pkg::noc_req_t   deser_req;
  logic                    deser_val;
  logic                    deser_rdy;
  mem_if_pkg::mem_rd_req_t read_req;
  logic                    read_req_val;
  logic                    read_req_rdy;
  mem_if_pkg::mem_wr_req_t write_req;
  logic                    write_req_val;
  logic                    write_req_rdy;
  mem_if_pkg::data_t       read_resp_data = '0;
  logic                    read_resp_val  = 1'b0;
  logic                    read_resp_rdy;
  logic                    write_resp_val = 1'b0;
  logic                    write_resp_rdy;
  noc_msg_pkg::noc_hdr_t   ser_hdr;
  mem_if_pkg::data_t       ser_data;
  logic                    ser_val;
  logic                    ser_rdy;

  logic                    rd_block;        // Memory withholds read responses
  logic                    bg_done;         // Background sender finished
  logic [31:0]             lcg_state;
  logic [7:0]              mshr_next = '0;
  int                      acc_count = 0;   // NoC requests accepted
  int                      resp_count = 0;  // NoC responses delivered
  noc_msg_pkg::noc_req_t   req_q[$];        // Accepted, not yet sent to memory
  pend_t                   pend_q[$];       // Sent to memory, awaiting NoC response

  noc_mem_bridge #(
    .IN_FLIGHT_DEPTH   (IN_FLIGHT_DEPTH),
    .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH),
    .ADDR_OFFSET       (ADDR_OFFSET)
  ) i_dut (.*);

  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference rules of the request and response conversion
  function automatic logic uncached(noc_msg_pkg::noc_hdr_t h);
    return h.addr[39] || (h.msg_type == noc_msg_pkg::msg_nc_load_req) ||
           (h.msg_type == noc_msg_pkg::msg_nc_store_req);
  endfunction

  function automatic logic store_type(noc_msg_pkg::noc_hdr_t h);
    return (h.msg_type == noc_msg_pkg::msg_store_mem) ||
           (h.msg_type == noc_msg_pkg::msg_nc_store_req);
  endfunction

  function automatic logic [2:0] exp_size_log(noc_msg_pkg::noc_hdr_t h);
    return uncached(h) ? h.data_size - 3'd1 : 3'd3;  // Cached is a whole word
  endfunction

  function automatic logic [2:0] exp_offset(noc_msg_pkg::noc_hdr_t h);
    return uncached(h) ? h.addr[2:0] : 3'd0;
  endfunction

  function automatic mem_if_pkg::addr_t exp_addr(noc_msg_pkg::noc_hdr_t h);
    mem_if_pkg::addr_t a;
    int                i;
    a = h.addr - ADDR_OFFSET;
    for (i = 0; i < 8; i++) begin
      if (i < exp_size_log(h)) a[i] = 1'b0;  // Align to the access size
    end
    return a;
  endfunction

  function automatic mem_if_pkg::mem_wr_req_t exp_wr_req(noc_msg_pkg::noc_req_t r);
    mem_if_pkg::mem_wr_req_t w;
    int                      i;
    w.addr     = exp_addr(r.hdr);
    w.size_log = exp_size_log(r.hdr);
    w.strb     = '0;
    for (i = 0; i < (1 << exp_size_log(r.hdr)); i++) begin
      if (i + exp_offset(r.hdr) < 8) w.strb[i + exp_offset(r.hdr)] = 1'b1;
    end
    w.data = r.data << (8 * exp_offset(r.hdr));
    return w;
  endfunction

  function automatic mem_if_pkg::data_t exp_resp_data(pend_t p);
    mem_if_pkg::data_t shifted;
    mem_if_pkg::data_t d;
    int                nbytes;
    int                i;
    if (store_type(p.req.hdr)) return '0;
    nbytes  = 1 << exp_size_log(p.req.hdr);
    shifted = p.mdata >> (8 * exp_offset(p.req.hdr));
    for (i = 0; i < 8; i++) d[8*i +: 8] = shifted[8*(i % nbytes) +: 8];  // Item repeated
    return d;
  endfunction

  task automatic abort_run(string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_mismatch(string msg);
    abort_run($sformatf("[ERROR] %0t ns: %s", $time, msg));
  endtask

  // Transfer checks sampled at the falling edge where all signals are settled
  a_ser_hold: assert property (@(negedge clk) disable iff (!rst_n)
    ser_val && !ser_rdy |=> ser_val && $stable(ser_hdr) && $stable(ser_data))
    else report_mismatch("NoC response changed while ser_rdy was low");

  a_rd_hold: assert property (@(negedge clk) disable iff (!rst_n)
    read_req_val && !read_req_rdy |=> read_req_val && $stable(read_req))
    else report_mismatch("read request changed while stalled");

  a_wr_hold: assert property (@(negedge clk) disable iff (!rst_n)
    write_req_val && !write_req_rdy |=> write_req_val && $stable(write_req))
    else report_mismatch("write request changed while stalled");

  a_one_channel: assert property (@(negedge clk) disable iff (!rst_n)
    !(read_resp_rdy && write_resp_rdy))
    else report_mismatch("both memory response channels ready");

  // A memory response is only taken together with its NoC response
  a_resp_pair: assert property (@(negedge clk) disable iff (!rst_n)
    (read_resp_val && read_resp_rdy) || (write_resp_val && write_resp_rdy) |->
      ser_val && ser_rdy)
    else report_mismatch("memory response accepted without a NoC response");

  always @(negedge clk) begin
    if (rst_n && deser_val && deser_rdy) begin
      req_q.push_back(deser_req);
      acc_count++;
    end
  end

  always @(negedge clk) begin
    noc_msg_pkg::noc_req_t   r;
    mem_if_pkg::mem_rd_req_t rd_exp;
    pend_t                   p;
    if (rst_n && ((read_req_val && read_req_rdy) || (write_req_val && write_req_rdy))) begin
      if (req_q.size() == 0) begin
        report_mismatch("memory request without an accepted NoC request");
      end else begin
        r       = req_q.pop_front();
        p.req   = r;
        p.mdata = {next_rand(), next_rand()};  // Word memory will return
        pend_q.push_back(p);
        rd_exp.addr     = exp_addr(r.hdr);
        rd_exp.size_log = exp_size_log(r.hdr);
        if (read_req_val) begin
          assert (!store_type(r.hdr) && read_req == rd_exp)
            else report_mismatch($sformatf("read req %h, expected %h", read_req, rd_exp));
        end else begin
          assert (store_type(r.hdr) && write_req == exp_wr_req(r))
            else report_mismatch($sformatf("write req %h, expected %h",
                                           write_req, exp_wr_req(r)));
        end
      end
    end
  end

  always @(negedge clk) begin
    pend_t p;
    if (rst_n && ser_val && ser_rdy) begin
      if (pend_q.size() == 0) begin
        report_mismatch("NoC response without an issued request");
      end else begin
        p = pend_q.pop_front();
        resp_count++;
        assert (ser_hdr == p.req.hdr && ser_data == exp_resp_data(p))
          else report_mismatch($sformatf("response hdr %h data %h, expected hdr %h data %h",
                                         ser_hdr, ser_data, p.req.hdr, exp_resp_data(p)));
        assert (store_type(p.req.hdr) ? (write_resp_val && write_resp_rdy)
                                      : (read_resp_val && read_resp_rdy))
          else report_mismatch("memory response not taken with its NoC response");
      end
    end
  end

  // Memory offers the oldest pending item of each kind on its channel
  always @(posedge clk) begin
    logic              ld_found;
    logic              st_found;
    mem_if_pkg::data_t ld_data;
    #2;
    ld_found = 1'b0;
    st_found = 1'b0;
    ld_data  = '0;
    foreach (pend_q[i]) begin
      if (store_type(pend_q[i].req.hdr)) begin
        st_found = 1'b1;
      end else if (!ld_found) begin
        ld_found = 1'b1;
        ld_data  = pend_q[i].mdata;
      end
    end
    read_resp_val  = ld_found && !rd_block;
    read_resp_data = ld_data;
    write_resp_val = st_found;
  end

  task automatic fill_req(noc_msg_pkg::msg_type_t t, mem_if_pkg::addr_t a, logic [2:0] dsize);
    logic [31:0] rnd;
    rnd = next_rand();
    deser_req.hdr.msg_type  = t;
    deser_req.hdr.mshrid    = mshr_next;
    deser_req.hdr.src_x     = rnd[7:0];
    deser_req.hdr.src_y     = rnd[15:8];
    deser_req.hdr.data_size = dsize;
    deser_req.hdr.addr      = a;
    deser_req.data          = {next_rand(), next_rand()};
    mshr_next++;
  endtask

  function automatic mem_if_pkg::addr_t rand_addr();
    logic [31:0] rnd;
    rnd = next_rand();
    return ADDR_OFFSET + {8'h00, rnd};
  endfunction

  // Uncacheable access of 1 << sl bytes at a random aligned offset
  task automatic fill_random(logic store, logic [2:0] sl);
    logic [31:0]       rnd;
    mem_if_pkg::addr_t a;
    rnd     = next_rand();
    a       = rand_addr();
    a[2:0]  = rnd[2:0] & (3'b111 << sl);
    fill_req(store ? noc_msg_pkg::msg_nc_store_req : noc_msg_pkg::msg_nc_load_req,
             a, sl + 3'd1);
  endtask

  task automatic offer_req();
    int waited;
    deser_val = 1'b1;
    waited    = 0;
    @(negedge clk);
    while (!deser_rdy && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (deser_rdy) begin
      @(posedge clk);
      #2;
      deser_val = 1'b0;
    end else begin
      abort_run("Timeout: the bridge did not accept a NoC request");
    end
  endtask

  task automatic send_burst(int n);
    int i;
    for (i = 0; i < n; i++) begin
      fill_random(i[0], 3'(i % 3));
      offer_req();
    end
    bg_done = 1'b1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (resp_count != acc_count && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (resp_count != acc_count) abort_run("Timeout: NoC responses still missing");
  endtask

  task automatic wait_issued(int n);
    int waited;
    waited = 0;
    while (pend_q.size() < n && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (pend_q.size() < n) abort_run("Timeout: memory requests were not issued");
  endtask

  task automatic wait_input_full();
    int waited;
    waited = 0;
    while (deser_rdy && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (deser_rdy) abort_run("Timeout: input queue never filled while responses stalled");
  endtask

  task automatic wait_sender();
    int waited;
    waited = 0;
    while (!bg_done && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!bg_done) abort_run("Timeout: background sender did not finish");
  endtask

  initial begin
    int                i;
    int                accepted;
    logic              full_seen;
    mem_if_pkg::addr_t a;
    lcg_state     = 32'd99784;
    rst_n         = 1'b0;
    deser_req     = '0;
    deser_val     = 1'b0;
    read_req_rdy  = 1'b1;
    write_req_rdy = 1'b1;
    ser_rdy       = 1'b1;
    rd_block      = 1'b0;
    bg_done       = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    @(negedge clk);
    assert (!read_req_val && !write_req_val && !read_resp_rdy && !write_resp_rdy &&
            !ser_val && deser_rdy)
      else report_mismatch("outputs not idle after reset");
    @(posedge clk);
    #2;

    // Cacheable load of a full word from an unaligned address
    fill_req(noc_msg_pkg::msg_load_mem, rand_addr(), 3'd4);
    offer_req();
    wait_drain();

    // Uncacheable stores then loads of each size at random offsets
    for (i = 0; i < 18; i++) begin
      fill_random(i < 9, 3'(i % 3));
      offer_req();
    end
    a      = rand_addr();
    a[39]  = 1'b1;   // Top bit makes a plain load uncacheable
    a[2:0] = 3'd6;
    fill_req(noc_msg_pkg::msg_load_mem, a, 3'd2);
    offer_req();
    fill_req(noc_msg_pkg::msg_store_mem, rand_addr(), 3'd4);
    offer_req();
    wait_drain();

    // Write response offered ahead of the older read response
    rd_block = 1'b1;
    fill_random(1'b0, 3'd2);
    offer_req();
    fill_random(1'b1, 3'd1);
    offer_req();
    wait_issued(2);
    repeat (5) begin
      @(negedge clk);
      assert (write_resp_val && !write_resp_rdy && !ser_val)
        else report_mismatch("write response taken ahead of the older load");
    end
    rd_block = 1'b0;
    @(posedge clk);
    #2;
    wait_drain();

    // Input queue fills while memory requests are stalled
    read_req_rdy  = 1'b0;
    write_req_rdy = 1'b0;
    accepted      = 0;
    full_seen     = 1'b0;
    for (i = 0; i < IN_FLIGHT_DEPTH + 2 && !full_seen; i++) begin
      fill_random(i[0], 3'(i % 3));
      deser_val = 1'b1;
      @(negedge clk);
      if (deser_rdy) accepted++;
      else full_seen = 1'b1;
      @(posedge clk);
      #2;
    end
    deser_val = 1'b0;
    assert (full_seen && accepted == IN_FLIGHT_DEPTH)
      else report_mismatch($sformatf("%0d requests accepted with memory stalled, expected %0d",
                                     accepted, IN_FLIGHT_DEPTH));

    // Outstanding queue then input queue fill while the NoC side is stalled
    ser_rdy       = 1'b0;
    read_req_rdy  = 1'b1;
    write_req_rdy = 1'b1;
    fork
      send_burst(IN_FLIGHT_DEPTH);
    join_none
    wait_input_full();
    repeat (8) @(posedge clk);
    #2;
    assert (ser_val) else report_mismatch("no NoC response offered while stalled");
    ser_rdy = 1'b1;
    wait_sender();
    wait_drain();

    $display("** PASS **");
    $finish;
  end

endmodule

// File: noc_mem_bridge.sv
// Memory-side bridge buffer between the NoC and a memory controller
// Input queue, request issuer, outstanding queue and response formatter
`timescale 1ns/10ps

module noc_mem_bridge #(
  parameter int                IN_FLIGHT_DEPTH   = 4,
  parameter int                OUTSTANDING_DEPTH = 4,
  parameter mem_if_pkg::addr_t ADDR_OFFSET       = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,

  // NoC requests in
  input  noc_msg_pkg::noc_req_t   deser_req,
  input  logic                    deser_val,
  output logic                    deser_rdy,

  // Memory requests out
  output mem_if_pkg::mem_rd_req_t read_req,
  output logic                    read_req_val,
  input  logic                    read_req_rdy,
  output mem_if_pkg::mem_wr_req_t write_req,
  output logic                    write_req_val,
  input  logic                    write_req_rdy,

  // Memory responses in, in request order
  input  mem_if_pkg::data_t       read_resp_data,
  input  logic                    read_resp_val,
  output logic                    read_resp_rdy,
  input  logic                    write_resp_val,
  output logic                    write_resp_rdy,

  // NoC responses out
  output noc_msg_pkg::noc_hdr_t   ser_hdr,
  output mem_if_pkg::data_t       ser_data,
  output logic                    ser_val,
  input  logic                    ser_rdy
);

  noc_msg_pkg::noc_req_t in_head;
  logic                  in_head_val;
  logic                  in_pop;
  logic                  in_full;

  noc_msg_pkg::noc_hdr_t outst_hdr;   // Header entering the outstanding queue
  noc_msg_pkg::noc_hdr_t outst_head;  // Oldest request awaiting its response
  logic                  outst_push;
  logic                  outst_pop;
  logic                  outst_val;
  logic                  outst_full;

  assign deser_rdy = !in_full;

  // Accepted NoC requests
  bridge_fifo #(
    .payload_t (noc_msg_pkg::noc_req_t),
    .DEPTH     (IN_FLIGHT_DEPTH)
  ) u_in_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (deser_val && deser_rdy),
    .push_data (deser_req),
    .pop       (in_pop),
    .head      (in_head),
    .head_val  (in_head_val),
    .full      (in_full)
  );

  mem_req_issuer #(
    .ADDR_OFFSET   (ADDR_OFFSET)
  ) u_issuer (
    .head          (in_head),
    .head_val      (in_head_val),
    .head_pop      (in_pop),
    .outst_full    (outst_full),
    .outst_push    (outst_push),
    .outst_hdr     (outst_hdr),
    .read_req      (read_req),
    .read_req_val  (read_req_val),
    .read_req_rdy  (read_req_rdy),
    .write_req     (write_req),
    .write_req_val (write_req_val),
    .write_req_rdy (write_req_rdy)
  );

  // Headers of requests issued to memory, oldest at the head
  bridge_fifo #(
    .payload_t (noc_msg_pkg::noc_hdr_t),
    .DEPTH     (OUTSTANDING_DEPTH)
  ) u_outst_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (outst_push),
    .push_data (outst_hdr),
    .pop       (outst_pop),
    .head      (outst_head),
    .head_val  (outst_val),
    .full      (outst_full)
  );

  mem_resp_formatter u_formatter (
    .outst_head     (outst_head),
    .outst_val      (outst_val),
    .outst_pop      (outst_pop),
    .read_resp_data (read_resp_data),
    .read_resp_val  (read_resp_val),
    .read_resp_rdy  (read_resp_rdy),
    .write_resp_val (write_resp_val),
    .write_resp_rdy (write_resp_rdy),
    .ser_hdr        (ser_hdr),
    .ser_data       (ser_data),
    .ser_val        (ser_val),
    .ser_rdy        (ser_rdy)
  );

endmodule

// File: mem_resp_formatter.sv
// Pairs memory responses with the oldest outstanding request
// Builds the NoC response header and data from them
`timescale 1ns/10ps

module mem_resp_formatter (
  // Outstanding queue head
  input  noc_msg_pkg::noc_hdr_t outst_head,
  input  logic                  outst_val,
  output logic                  outst_pop,

  // Memory read response
  input  mem_if_pkg::data_t     read_resp_data,
  input  logic                  read_resp_val,
  output logic                  read_resp_rdy,

  // Memory write response
  input  logic                  write_resp_val,
  output logic                  write_resp_rdy,

  // NoC response
  output noc_msg_pkg::noc_hdr_t ser_hdr,
  output mem_if_pkg::data_t     ser_data,
  output logic                  ser_val,
  input  logic                  ser_rdy
);

  logic                              head_store;
  logic                              resp_val;
  logic                              ser_go;
  logic [mem_if_pkg::SIZE_LOG_W-1:0] size_log;
  logic [mem_if_pkg::OFFS_W-1:0]     offset;
  mem_if_pkg::data_t                 rdata_shifted;
  mem_if_pkg::data_t                 rdata;

  assign head_store = noc_msg_pkg::is_store(outst_head);
  assign size_log   = noc_msg_pkg::size_log_of(outst_head);
  assign offset     = noc_msg_pkg::offset_of(outst_head);

  // Listen only to the channel the head request expects
  assign resp_val = head_store ? write_resp_val : read_resp_val;

  assign ser_val = outst_val && resp_val;
  assign ser_go  = ser_val && ser_rdy;

  // Other channel stays blocked so responses keep request order
  assign read_resp_rdy  = outst_val && !head_store && ser_rdy;
  assign write_resp_rdy = outst_val && head_store && ser_rdy;

  assign outst_pop = ser_go;

  // Bring the addressed item down to byte 0
  assign rdata_shifted = read_resp_data >> {offset, 3'b000};

  // Replicate the item across the whole word
  always_comb begin
    case (size_log)
      3'd0:    rdata = {8{rdata_shifted[7:0]}};
      3'd1:    rdata = {4{rdata_shifted[15:0]}};
      3'd2:    rdata = {2{rdata_shifted[31:0]}};
      default: rdata = rdata_shifted;  // Full word
    endcase
  end

  assign ser_hdr  = outst_head;
  assign ser_data = head_store ? '0 : rdata;  // Write acks carry no data

endmodule

// File: mem_req_issuer.sv
// Turns the queued NoC request into a memory read or write request
// Records the issued header in the outstanding queue
`timescale 1ns/10ps

module mem_req_issuer #(
  parameter mem_if_pkg::addr_t ADDR_OFFSET = '0
) (
  // Input queue head
  input  noc_msg_pkg::noc_req_t   head,
  input  logic                    head_val,
  output logic                    head_pop,

  // Outstanding queue tail
  input  logic                    outst_full,
  output logic                    outst_push,
  output noc_msg_pkg::noc_hdr_t   outst_hdr,

  // Memory read request
  output mem_if_pkg::mem_rd_req_t read_req,
  output logic                    read_req_val,
  input  logic                    read_req_rdy,

  // Memory write request
  output mem_if_pkg::mem_wr_req_t write_req,
  output logic                    write_req_val,
  input  logic                    write_req_rdy
);

  noc_msg_pkg::noc_hdr_t                hdr;
  logic                                 store;
  logic                                 issue_ok;
  logic                                 req_go;
  logic [mem_if_pkg::SIZE_LOG_W-1:0]    size_log;
  logic [mem_if_pkg::OFFS_W-1:0]        offset;
  logic [mem_if_pkg::OFFS_W:0]          size_bytes;
  logic [mem_if_pkg::DATA_BYTES:0]      strb_ones;
  mem_if_pkg::addr_t                    base_addr;
  mem_if_pkg::addr_t                    req_addr;
  mem_if_pkg::strb_t                    strb;
  mem_if_pkg::data_t                    wdata;

  assign hdr      = head.hdr;
  assign store    = noc_msg_pkg::is_store(hdr);
  assign size_log = noc_msg_pkg::size_log_of(hdr);
  assign offset   = noc_msg_pkg::offset_of(hdr);

  // Request goes out only when there is room to remember it
  assign issue_ok = head_val && !outst_full;

  assign read_req_val  = issue_ok && !store;
  assign write_req_val = issue_ok && store;

  assign req_go = (read_req_val && read_req_rdy) || (write_req_val && write_req_rdy);

  // Dequeue and record in the same cycle as the memory transfer
  assign head_pop   = req_go;
  assign outst_push = req_go;
  assign outst_hdr  = hdr;

  // Remove the base offset, then clear the bits below the access size
  assign base_addr = hdr.addr - ADDR_OFFSET;
  assign req_addr  = base_addr & (mem_if_pkg::addr_t'('1) << size_log);

  // size_bytes ones in the low lanes, moved up to the byte offset
  assign size_bytes = (mem_if_pkg::OFFS_W + 1)'(1) << size_log;
  assign strb_ones  = ((mem_if_pkg::DATA_BYTES + 1)'(1) << size_bytes) - 1'b1;
  assign strb       = strb_ones[mem_if_pkg::DATA_BYTES-1:0] << offset;

  // Item sits in the low bytes of the NoC word
  assign wdata = head.data << {offset, 3'b000};

  assign read_req.addr     = req_addr;
  assign read_req.size_log = size_log;

  assign write_req.addr     = req_addr;
  assign write_req.size_log = size_log;
  assign write_req.data     = wdata;
  assign write_req.strb     = strb;

endmodule

// File: bridge_fifo.sv
// First-word-fall-through queue over a register array
// Payload type and depth are set by the instantiating module
`timescale 1ns/10ps

module bridge_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     head_val,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Entries held

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap explicitly so DEPTH need not be a power of two
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  // Oldest entry shown without a read cycle
  assign head     = mem[rd_ptr];
  assign head_val = (count != '0);
  assign full     = (count == CNT_W'(DEPTH));

endmodule

// File: noc_msg_pkg.sv
// NoC message header and request payload structs
// Message type codes and the size and offset rules of a request
package noc_msg_pkg;

  localparam int SIZE_W     = 3;   // Encoded data_size field
  localparam int NOC_ADDR_W = 40;  // Physical address carried in the header

  typedef logic [7:0] msg_type_t;

  // Request types the memory side understands
  localparam msg_type_t msg_load_mem     = 8'd19;
  localparam msg_type_t msg_store_mem    = 8'd20;
  localparam msg_type_t msg_nc_load_req  = 8'd14;
  localparam msg_type_t msg_nc_store_req = 8'd15;

  typedef struct packed {
    msg_type_t             msg_type;
    logic [7:0]            mshrid;     // Returned unchanged to the requester
    logic [7:0]            src_x;
    logic [7:0]            src_y;
    logic [SIZE_W-1:0]     data_size;  // 1, 2, 3, 4 for 1, 2, 4, 8 bytes
    logic [NOC_ADDR_W-1:0] addr;
  } noc_hdr_t;

  // Header together with its write data word
  typedef struct packed {
    noc_hdr_t          hdr;
    mem_if_pkg::data_t data;
  } noc_req_t;

  function automatic logic is_store(noc_hdr_t hdr);
    return (hdr.msg_type == msg_store_mem) || (hdr.msg_type == msg_nc_store_req);
  endfunction

  // Top address bit or an NC type marks an uncacheable access
  function automatic logic is_uncacheable(noc_hdr_t hdr);
    return hdr.addr[NOC_ADDR_W-1] ||
           (hdr.msg_type == msg_nc_load_req) ||
           (hdr.msg_type == msg_nc_store_req);
  endfunction

  // Cacheable accesses always move the whole word
  function automatic logic [mem_if_pkg::SIZE_LOG_W-1:0] size_log_of(noc_hdr_t hdr);
    return is_uncacheable(hdr) ? hdr.data_size - 3'd1 : mem_if_pkg::OFFS_W[2:0];
  endfunction

  function automatic logic [mem_if_pkg::OFFS_W-1:0] offset_of(noc_hdr_t hdr);
    return is_uncacheable(hdr) ? hdr.addr[mem_if_pkg::OFFS_W-1:0] : '0;
  endfunction

endpackage

// File: mem_if_pkg.sv
// Memory-side widths and data types
// Read and write request structs sent to the memory controller
package mem_if_pkg;

  localparam int DATA_W     = 64;
  localparam int DATA_BYTES = DATA_W / 8;
  localparam int OFFS_W     = $clog2(DATA_BYTES);  // Byte offset inside a word
  localparam int ADDR_W     = 40;
  localparam int SIZE_LOG_W = 3;                   // log2 of the access size in bytes

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_BYTES-1:0] strb_t;
  typedef logic [ADDR_W-1:0]     addr_t;

  // Read request, address already aligned to the access size
  typedef struct packed {
    addr_t                 addr;
    logic [SIZE_LOG_W-1:0] size_log;
  } mem_rd_req_t;

  // Write request, data already placed at its byte lanes
  typedef struct packed {
    addr_t                 addr;
    logic [SIZE_LOG_W-1:0] size_log;
    data_t                 data;
    strb_t                 strb;   // One bit per byte lane
  } mem_wr_req_t;

endpackage
